/* build.f */
logic/smc_bus_pkg.sv
logic/smc_timing_pkg.sv
logic/smc_cycle_ctrl.sv
logic/smc_bus_drive.sv
logic/smc_wr_enable.sv
logic/smc_rd_capture.sv
logic/smc_top.sv
dv/smc_sram_model.sv
dv/smc_assert.sv
dv/smc_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the static memory controller testbench with Verilator and runs it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module smc_tb -Mdir obj_dir -o smc_sim -f build.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build returned status $status"
  exit "$status"
fi

./obj_dir/smc_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation run returned status $status"
  exit "$status"
fi

exit 0

/* dv/smc_tb.sv */
//----------------------------------------------------------------------
// testbench for the static memory controller
// random reads and writes over a 64 word window
// pins checked each cycle and read data against a word model
//----------------------------------------------------------------------
`timescale 1ns/100ps

module smc_tb;

  import smc_bus_pkg::*;
  import smc_timing_pkg::*;

  localparam int CLK_HALF     = 50;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_ACCESSES = 400;
  // access plus the cycle with ready back high
  localparam int ACCESS_PERIOD  = SMC_ACCESS_CYCLES + 1;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ACCESSES * ACCESS_PERIOD + 200;
  // upper address bits fixed and low 6 bits free for the window
  localparam smc_addr_t WIN_BASE = 16'h3a40;

  logic          sys_clk = 1'b0;
  logic          rst;
  logic          host_req;
  smc_host_req_t host_cmd;
  logic          ready;
  smc_data_t     rd_data;
  logic          rd_valid;
  smc_mem_bus_t  mem_bus;
  smc_data_t     mem_rdata;

  integer        seed;
  int            cycle_cnt = 0;
  // expected SRAM words over the window
  smc_data_t     ref_mem [64];

  always #CLK_HALF sys_clk = ~sys_clk;

  smc_top i_dut (
    .sys_clk   (sys_clk),
    .rst       (rst),
    .host_req  (host_req),
    .host_cmd  (host_cmd),
    .ready     (ready),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .mem_bus   (mem_bus),
    .mem_rdata (mem_rdata)
  );

  smc_sram_model i_sram (
    .mem_bus   (mem_bus),
    .mem_rdata (mem_rdata)
  );

  //--------------------------------------------------------------------
  // reference values
  //--------------------------------------------------------------------
  // unwritten word reads {~addr, addr} as in the SRAM model
  function automatic smc_data_t fill_word(input smc_addr_t a);
    return {~a, a};
  endfunction

  function automatic smc_data_t lane_mask(input smc_be_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // expected pins in each step of an access
  // step 1 is setup and step 0 the idle cycle after hold
  function automatic smc_mem_bus_t access_bus(input smc_host_req_t cmd, input int step);
    smc_mem_bus_t b;
    b.addr  = cmd.addr;
    b.wdata = cmd.data;
    b.n_cs  = (step == 0);
    b.n_oe  = 1'b1;
    b.n_we  = '1;
    b.n_wr  = 1'b1;
    if (step > SMC_SETUP_CYCLES && step <= SMC_SETUP_CYCLES + SMC_STROBE_CYCLES)
    begin
      if (cmd.wr)
      begin
        b.n_we = ~cmd.be;
        b.n_wr = 1'b0;
      end
      else
        b.n_oe = 1'b0;
    end
    return b;
  endfunction

  //--------------------------------------------------------------------
  // compare tasks for each kind of result
  //--------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic compare_rdata(input string name, input smc_data_t exp, input smc_data_t act);
    if (act !== exp)
    begin
      $display("error: %s expected %h actual %h", name, exp, act);
      abort_run("read data mismatch");
    end
  endtask

  task automatic compare_bus(input string name, input smc_mem_bus_t exp,
                             input smc_mem_bus_t act);
    if (act !== exp)
    begin
      $display("error: %s expected %h actual %h", name, exp, act);
      abort_run("memory bus mismatch");
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("error: %s expected %b actual %b", name, exp, act);
      abort_run("control flag mismatch");
    end
  endtask

  // one access from request to the ready cycle
  // pins checked in every cycle of it
  task automatic run_access(input smc_host_req_t cmd, input logic [5:0] idx, input int n);
    int    step;
    string tag;
    tag = $sformatf("access %0d", n);
    host_req = 1'b1;
    host_cmd = cmd;
    @(negedge sys_clk);
    host_req = 1'b0;
    // scrambled so only the captured copy can match
    host_cmd = ~cmd;
    step     = 1;
    while (!ready)
    begin
      if (step > SMC_ACCESS_CYCLES)
        abort_run($sformatf("%s: ready still low after %0d cycles", tag, step));
      compare_bus({tag, " bus"}, access_bus(cmd, step), mem_bus);
      compare_flag({tag, " rd_valid early"}, 1'b0, rd_valid);
      @(negedge sys_clk);
      step++;
    end
    if (step != ACCESS_PERIOD)
      abort_run($sformatf("%s: ready back after %0d cycles, not %0d", tag, step,
                          ACCESS_PERIOD));
    compare_bus({tag, " idle bus"}, access_bus(cmd, 0), mem_bus);
    compare_flag({tag, " rd_valid"}, ~cmd.wr, rd_valid);
    if (cmd.wr)
      ref_mem[idx] = (ref_mem[idx] & ~lane_mask(cmd.be)) | (cmd.data & lane_mask(cmd.be));
    else
      compare_rdata({tag, " rd_data"}, ref_mem[idx], rd_data);
  endtask

  //--------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------
  initial
  begin
    smc_host_req_t cmd;
    logic [31:0]   rnd;
    logic [5:0]    idx;
    seed     = 32'hf9f1c2f0;
    rst      = 1'b1;
    host_req = 1'b0;
    host_cmd = '0;
    for (int i = 0; i < 64; i++)
      ref_mem[i[5:0]] = fill_word(WIN_BASE + smc_addr_t'(i));
    repeat (RESET_CYCLES) @(negedge sys_clk);
    rst = 1'b0;
    @(negedge sys_clk);
    // idle pins straight out of reset
    compare_flag("reset ready", 1'b1, ready);
    compare_flag("reset rd_valid", 1'b0, rd_valid);
    compare_flag("reset n_cs", 1'b1, mem_bus.n_cs);
    compare_flag("reset n_oe", 1'b1, mem_bus.n_oe);
    compare_flag("reset n_wr", 1'b1, mem_bus.n_wr);
    compare_flag("reset n_we", 1'b1, &mem_bus.n_we);
    for (int n = 0; n < NUM_ACCESSES; n++)
    begin
      rnd      = $random(seed);
      idx      = rnd[6:1];
      cmd.wr   = rnd[0];
      cmd.be   = rnd[10:7];
      cmd.addr = WIN_BASE + smc_addr_t'(idx);
      cmd.data = $random(seed);
      run_access(cmd, idx, n);
      // mostly back to back with now and then one idle cycle
      if (rnd[15:13] == 3'd0)
      begin
        @(negedge sys_clk);
        compare_bus("gap bus", access_bus(cmd, 0), mem_bus);
        compare_flag("gap rd_valid", 1'b0, rd_valid);
        compare_flag("gap ready", 1'b1, ready);
      end
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  // run length guard
  always @(posedge sys_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      abort_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

endmodule

/* dv/smc_assert.sv */
//----------------------------------------------------------------------
// concurrent checks on the SRAM strobes and the host request rule
// bound into every smc_top instance
//----------------------------------------------------------------------
`timescale 1ns/100ps

module smc_assert (
  input logic                      sys_clk,
  input logic                      rst,
  input logic                      host_req,
  input logic                      ready,
  input smc_bus_pkg::smc_mem_bus_t mem_bus
);

  // any write pin low in this cycle
  logic wr_active;
  assign wr_active = !mem_bus.n_wr || (mem_bus.n_we != '1);

  // write pulse only under chip select
  wr_inside_cs: assert property (@(posedge sys_clk) disable iff (rst)
    wr_active |-> !mem_bus.n_cs)
    else $error("write pin active while chip select is high");

  // SRAM never written and read at once
  no_we_with_oe: assert property (@(posedge sys_clk) disable iff (rst)
    !((mem_bus.n_we != '1) && !mem_bus.n_oe))
    else $error("byte write enable and output enable low together");

  // host waits for ready
  req_when_ready: assert property (@(posedge sys_clk) disable iff (rst)
    host_req |-> ready)
    else $error("host_req pulsed while ready is low");

endmodule

bind smc_top smc_assert i_assert (
  .sys_clk  (sys_clk),
  .rst      (rst),
  .host_req (host_req),
  .ready    (ready),
  .mem_bus  (mem_bus)
);

/* dv/smc_sram_model.sv */
//----------------------------------------------------------------------
// behavioural asynchronous SRAM on the controller pins
// unwritten words read as {~addr, addr}, byte lanes are committed
// when the write strobe rises
//----------------------------------------------------------------------
`timescale 1ns/100ps

module smc_sram_model (
  input  smc_bus_pkg::smc_mem_bus_t mem_bus,
  output smc_bus_pkg::smc_data_t    mem_rdata
);

  import smc_bus_pkg::*;

  localparam int DEPTH = 1 << $bits(smc_addr_t);
  // lane enables are taken a little after the strobe falls
  localparam int WE_SETTLE = 1;

  smc_data_t mem [DEPTH];
  logic      n_wr;
  smc_data_t wr_mask = '0;

  assign n_wr = mem_bus.n_wr;

  // fill value, covers the whole address
  function automatic smc_data_t fill_word(input smc_addr_t a);
    return {~a, a};
  endfunction

  // one byte of mask per enabled lane
  function automatic smc_data_t lane_mask(input smc_be_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      mem[smc_addr_t'(i)] = fill_word(smc_addr_t'(i));
  end

  // lanes once the pins have settled inside the strobe
  always @(negedge n_wr)
  begin
    #WE_SETTLE;
    wr_mask = lane_mask(~mem_bus.n_we);
  end

  // commit at the end of the pulse, address and data still held
  always @(posedge n_wr)
  begin
    if (!mem_bus.n_cs)
      mem[mem_bus.addr] = (mem[mem_bus.addr] & ~wr_mask) | (mem_bus.wdata & wr_mask);
  end

  // word driven only with chip select and output enable low
  assign mem_rdata = (!mem_bus.n_cs && !mem_bus.n_oe) ? mem[mem_bus.addr] : '0;

endmodule

/* logic/smc_top.sv */
//----------------------------------------------------------------------
// static memory controller top, single accesses to an async SRAM
// host pulses host_req with host_cmd while ready is high
//----------------------------------------------------------------------
`timescale 1ns/100ps

module smc_top (
  input  logic                       sys_clk,
  input  logic                       rst,
  input  logic                       host_req,
  input  smc_bus_pkg::smc_host_req_t host_cmd,
  output logic                       ready,
  output smc_bus_pkg::smc_data_t     rd_data,
  output logic                       rd_valid,
  output smc_bus_pkg::smc_mem_bus_t  mem_bus,
  input  smc_bus_pkg::smc_data_t     mem_rdata
);

  import smc_bus_pkg::*;
  import smc_timing_pkg::*;

  logic         cmd_load;
  smc_phase_e   phase;
  logic         r_full;
  logic         rd_sample;
  smc_mem_bus_t bus_regs;
  smc_be_t      n_r_we;
  logic         n_r_wr;
  smc_be_t      n_we;
  logic         n_wr;

  //--------------------------------------------------------------------
  // sequencer, bus registers, write gate, read capture
  //--------------------------------------------------------------------
  smc_cycle_ctrl i_cycle_ctrl (
    .sys_clk   (sys_clk),
    .rst       (rst),
    .host_req  (host_req),
    .ready     (ready),
    .cmd_load  (cmd_load),
    .phase     (phase),
    .r_full    (r_full),
    .rd_sample (rd_sample)
  );

  smc_bus_drive i_bus_drive (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .cmd_load (cmd_load),
    .host_cmd (host_cmd),
    .phase    (phase),
    .bus_regs (bus_regs),
    .n_r_we   (n_r_we),
    .n_r_wr   (n_r_wr)
  );

  smc_wr_enable i_wr_enable (
    .r_full (r_full),
    .n_r_we (n_r_we),
    .n_r_wr (n_r_wr),
    .n_we   (n_we),
    .n_wr   (n_wr)
  );

  // registered write strobe high marks a read
  smc_rd_capture i_rd_capture (
    .sys_clk   (sys_clk),
    .rst       (rst),
    .rd_sample (rd_sample),
    .is_read   (n_r_wr),
    .mem_rdata (mem_rdata),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

  // gated write pins replace the raw ones
  always_comb
  begin
    mem_bus      = bus_regs;
    mem_bus.n_we = n_we;
    mem_bus.n_wr = n_wr;
  end

endmodule

/* logic/smc_rd_capture.sv */
//----------------------------------------------------------------------
// read data capture, samples the SRAM at the end of the strobe phase
// rd_valid pulses together with ready returning high
//----------------------------------------------------------------------
`timescale 1ns/100ps

module smc_rd_capture (
  input  logic                   sys_clk,
  input  logic                   rst,
  input  logic                   rd_sample,
  input  logic                   is_read,
  input  smc_bus_pkg::smc_data_t mem_rdata,
  output smc_bus_pkg::smc_data_t rd_data,
  output logic                   rd_valid
);

  // sample taken, valid goes out during the idle return
  logic rd_pend;

  // data word, kept until the next read
  always_ff @(posedge sys_clk)
  begin
    if (rd_sample && is_read)
      rd_data <= mem_rdata;
  end

  always_ff @(posedge sys_clk)
  begin
    if (rst)
    begin
      rd_pend  <= 1'b0;
      rd_valid <= 1'b0;
    end
    else
    begin
      // writes never raise valid
      rd_pend  <= rd_sample & is_read;
      rd_valid <= rd_pend;
    end
  end

endmodule

/* logic/smc_wr_enable.sv */
//----------------------------------------------------------------------
// write pin gate, keeps the SRAM write pulse inside the strobe window
// purely combinational, sits between bus driver and pins
//----------------------------------------------------------------------
`timescale 1ns/100ps

module smc_wr_enable (
  input  logic                 r_full,
  input  smc_bus_pkg::smc_be_t n_r_we,
  input  logic                 n_r_wr,
  output smc_bus_pkg::smc_be_t n_we,
  output logic                 n_wr
);

  import smc_bus_pkg::*;

  // per lane write enable
  // forced high outside the strobe phase
  always_comb
  begin
    n_we = n_r_we | {$bits(smc_be_t){~r_full}};
  end

  // write strobe, same window as the enables
  always_comb
  begin
    n_wr = n_r_wr | ~r_full;
  end

endmodule

/* logic/smc_bus_drive.sv */
//----------------------------------------------------------------------
// SRAM bus register stage
// holds address, write data and the ungated write enables for one
// access; chip and output enable follow the sequencer phase
//----------------------------------------------------------------------
`timescale 1ns/100ps

module smc_bus_drive (
  input  logic                       sys_clk,
  input  logic                       rst,
  input  logic                       cmd_load,
  input  smc_bus_pkg::smc_host_req_t host_cmd,
  input  smc_timing_pkg::smc_phase_e phase,
  output smc_bus_pkg::smc_mem_bus_t  bus_regs,
  output smc_bus_pkg::smc_be_t       n_r_we,
  output logic                       n_r_wr
);

  import smc_bus_pkg::*;
  import smc_timing_pkg::*;

  smc_addr_t addr_q;
  smc_data_t wdata_q;

  // address and data stay put from setup through hold
  always_ff @(posedge sys_clk)
  begin
    if (cmd_load)
    begin
      addr_q  <= host_cmd.addr;
      wdata_q <= host_cmd.data;
    end
  end

  //--------------------------------------------------------------------
  // write enables, active low
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk)
  begin
    if (rst)
    begin
      n_r_we <= '1;
      n_r_wr <= 1'b1;
    end
    else if (cmd_load)
    begin
      // lane low only for a write with its byte enable set
      n_r_we <= ~(host_cmd.be & {$bits(smc_be_t){host_cmd.wr}});
      n_r_wr <= ~host_cmd.wr;
    end
    else if (phase == SMC_PH_IDLE)
    begin
      // access over
      n_r_we <= '1;
      n_r_wr <= 1'b1;
    end
  end

  // phase is gray coded, so these decodes switch cleanly
  always_comb
  begin
    bus_regs.addr  = addr_q;
    bus_regs.wdata = wdata_q;
    bus_regs.n_cs  = (phase == SMC_PH_IDLE);
    // n_r_wr high means the access is a read
    bus_regs.n_oe  = ~((phase == SMC_PH_STROBE) && n_r_wr);
    bus_regs.n_we  = n_r_we;
    bus_regs.n_wr  = n_r_wr;
  end

endmodule

/* logic/smc_cycle_ctrl.sv */
//----------------------------------------------------------------------
// phase sequencer of the static memory controller
// runs setup, strobe and hold for each accepted host request
// and flags the strobe window and its final cycle
//----------------------------------------------------------------------
`timescale 1ns/100ps

module smc_cycle_ctrl (
  input  logic                       sys_clk,
  input  logic                       rst,
  input  logic                       host_req,
  output logic                       ready,
  output logic                       cmd_load,
  output smc_timing_pkg::smc_phase_e phase,
  output logic                       r_full,
  output logic                       rd_sample
);

  import smc_timing_pkg::*;

  // remaining cycles in the current phase, 0 on its last cycle
  logic [SMC_WAIT_W-1:0] cnt;

  // next state
  smc_phase_e            phase_d;
  logic [SMC_WAIT_W-1:0] cnt_d;

  // accept only while idle, a pulse during an access is dropped
  assign cmd_load = host_req & ready;

  //--------------------------------------------------------------------
  // next phase and counter
  //--------------------------------------------------------------------
  always_comb
  begin
    phase_d = phase;
    cnt_d   = cnt;
    case (phase)
      SMC_PH_IDLE:
      begin
        if (cmd_load)
        begin
          phase_d = SMC_PH_SETUP;
          cnt_d   = SMC_WAIT_W'(SMC_SETUP_CYCLES - 1);
        end
      end
      SMC_PH_SETUP:
      begin
        if (cnt == '0)
        begin
          phase_d = SMC_PH_STROBE;
          cnt_d   = SMC_WAIT_W'(SMC_STROBE_CYCLES - 1);
        end
        else
          cnt_d = cnt - 1'b1;
      end
      SMC_PH_STROBE:
      begin
        if (cnt == '0)
        begin
          phase_d = SMC_PH_HOLD;
          cnt_d   = SMC_WAIT_W'(SMC_HOLD_CYCLES - 1);
        end
        else
          cnt_d = cnt - 1'b1;
      end
      default:
      begin
        // hold, back to idle when done
        if (cnt == '0)
          phase_d = SMC_PH_IDLE;
        else
          cnt_d = cnt - 1'b1;
      end
    endcase
  end

  //--------------------------------------------------------------------
  // state and flags, all decoded from the next state
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk)
  begin
    if (rst)
    begin
      phase     <= SMC_PH_IDLE;
      cnt       <= '0;
      ready     <= 1'b1;
      r_full    <= 1'b0;
      rd_sample <= 1'b0;
    end
    else
    begin
      phase     <= phase_d;
      cnt       <= cnt_d;
      ready     <= (phase_d == SMC_PH_IDLE);
      // strobe window only, write qualification is in the enables
      r_full    <= (phase_d == SMC_PH_STROBE);
      // last strobe cycle, read data settled
      rd_sample <= (phase_d == SMC_PH_STROBE) && (cnt_d == '0);
    end
  end

endmodule

/* logic/smc_timing_pkg.sv */
//----------------------------------------------------------------------
// fixed access timing of the static memory controller
// phase lengths in sys_clk cycles and the phase encoding
//----------------------------------------------------------------------

package smc_timing_pkg;

  // phase lengths, each at least one cycle
  localparam int SMC_SETUP_CYCLES  = 1;
  localparam int SMC_STROBE_CYCLES = 2;
  localparam int SMC_HOLD_CYCLES   = 1;

  // whole access with chip select low
  localparam int SMC_ACCESS_CYCLES = SMC_SETUP_CYCLES + SMC_STROBE_CYCLES + SMC_HOLD_CYCLES;

  // phase down counter, wide enough for the longest phase
  localparam int SMC_WAIT_W = 2;

  // gray sequence, one bit flips per phase step
  typedef enum logic [1:0] {
    SMC_PH_IDLE   = 2'b00,
    SMC_PH_SETUP  = 2'b01,
    SMC_PH_STROBE = 2'b11,
    SMC_PH_HOLD   = 2'b10
  } smc_phase_e;

endpackage

/* logic/smc_bus_pkg.sv */
//----------------------------------------------------------------------
// host request and SRAM pin types for the static memory controller
// shared by the RTL blocks and the testbench
//----------------------------------------------------------------------

package smc_bus_pkg;

  // word address into the external SRAM
  typedef logic [15:0] smc_addr_t;

  // one data word, 4 byte lanes
  typedef logic [31:0] smc_data_t;

  // byte enables, active high, one per lane
  typedef logic [3:0] smc_be_t;

  // single host access as presented with host_req
  typedef struct packed {
    logic      wr;
    smc_addr_t addr;
    smc_data_t data;
    smc_be_t   be;
  } smc_host_req_t;

  // pins towards the asynchronous SRAM
  // strobes and enables are all active low
  typedef struct packed {
    smc_addr_t addr;
    smc_data_t wdata;
    logic      n_cs;
    logic      n_oe;
    smc_be_t   n_we;
    logic      n_wr;
  } smc_mem_bus_t;

endpackage
